// ==== src.f ====
common/rgmii_pkg.sv
common/wb_regs_pkg.sv
rgmii_rx/rgmii_rx.sv
src/rx_fifo.sv
src/rx_wb_regs.sv
src/rgmii_rx_top.sv
bench/rgmii_rx_chk.sv
bench/tb_rgmii_rx.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the RGMII receive testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter project root"
	exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f src.f --top-module tb_rgmii_rx --Mdir obj_dir -o tb_rgmii_rx
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_rgmii_rx
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi
exit 0

// ==== bench/tb_rgmii_rx.sv ====
`timescale 1ns/1ps

module tb_rgmii_rx import rgmii_pkg::*, wb_regs_pkg::*;;

	localparam int DEPTH       = 16;
	localparam int ACK_TIMEOUT = 20;
	// Inter-frame nibble with full duplex, 1000 and link up
	localparam logic [3:0] IDLE_NIB = {1'b1, SPEED_1000, 1'b1};

	logic                clk_div;
	logic                reset;
	logic [3:0]          rxd_r_i;
	logic [3:0]          rxd_f_i;
	logic                rxctl_r_i;
	logic                rxctl_f_i;
	logic                wb_cyc_i;
	logic                wb_stb_i;
	logic                wb_we_i;
	logic [WB_ADR_W-1:0] wb_adr_i;
	logic [WB_DAT_W-1:0] wb_dat_i;
	logic                wb_ack_o;
	logic [WB_DAT_W-1:0] wb_dat_o;

	logic [31:0]        lfsr;
	logic [ENTRY_W-1:0] ref_q [$];
	logic [31:0]        rdat;

	rgmii_rx_top #(.FIFO_DEPTH(DEPTH)) dut (.*);

	bind rgmii_rx_top rgmii_rx_chk #(.FIFO_DEPTH(FIFO_DEPTH)) chk (
		.clk_div(clk_div), .reset(reset), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
		.ack_i(wb_ack_o), .level_i(level), .wr_en_i(wr_en)
	);

	always #50 clk_div = ~clk_div;

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		for (int k = 0; k < 8; k++) begin
			lfsr = lfsr_step(lfsr);
			b    = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	// One clk_div worth of line nibbles
	task automatic line_cycle(input logic [3:0] r, input logic [3:0] f,
		input logic cr, input logic cf);
		@(posedge clk_div);
		#1;
		rxd_r_i   = r;
		rxd_f_i   = f;
		rxctl_r_i = cr;
		rxctl_f_i = cf;
	endtask

	task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
		input logic [31:0] wdat, output logic [31:0] dat);
		int waited = 0;
		@(posedge clk_div);
		#1;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_adr_i = adr;
		wb_dat_i = wdat;
		do begin
			@(posedge clk_div);
			#1;
			waited++;
			if (waited > ACK_TIMEOUT)
				fail_run("wishbone ack did not arrive in time");
		end while (!wb_ack_o);
		dat = wb_dat_o;
		// Strobe stays up through the ack cycle and drops in the next one
		@(posedge clk_div);
		#1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	// Gigabit bytes with the falling nibble high and errors on rxctl_f
	task automatic send_gig(input int n, input int err_idx);
		logic [7:0] b;
		logic       err;
		for (int i = 0; i < n; i++) begin
			rand_byte(b);
			err = (i == err_idx);
			line_cycle(b[3:0], b[7:4], 1'b1, !err);
			ref_q.push_back({i == n - 1, err, b});
		end
		// Room for the flush and the queue write
		repeat (4) line_cycle(IDLE_NIB, 4'h0, 1'b0, 1'b0);
	endtask

	// 10/100 bytes as two rising nibbles with the low one first
	task automatic send_mii(input int n, input int err_idx, input logic err_hi);
		logic [7:0] b;
		logic       elo;
		logic       ehi;
		for (int i = 0; i < n; i++) begin
			rand_byte(b);
			elo = (i == err_idx) && !err_hi;
			ehi = (i == err_idx) && err_hi;
			line_cycle(b[3:0], 4'h0, 1'b1, !elo);
			line_cycle(b[7:4], 4'h0, 1'b1, !ehi);
			ref_q.push_back({i == n - 1, elo | ehi, b});
		end
		repeat (4) line_cycle(IDLE_NIB, 4'h0, 1'b0, 1'b0);
	endtask

	task automatic read_expect();
		logic [ENTRY_W-1:0] e;
		logic [31:0]        exp;
		if (ref_q.size() == 0)
			fail_run("data read with nothing left in the reference queue");
		e   = ref_q.pop_front();
		exp = {1'b1, 21'h0, e};
		wb_access(1'b0, REG_DATA, 32'h0, rdat);
		assert (rdat == exp)
			else fail_run($sformatf("error wb_dat_o got %h expected %h", rdat, exp));
	endtask

	task automatic expect_empty();
		wb_access(1'b0, REG_DATA, 32'h0, rdat);
		assert (rdat[31] == 1'b0)
			else fail_run($sformatf("error wb_dat_o[31] got %h expected 0", rdat[31]));
	endtask

	task automatic check_status(input logic [4:0] lvl, input logic ovf);
		logic [31:0] exp;
		exp = {16'h0, 3'b0, lvl, 3'b0, ovf, IDLE_NIB};
		wb_access(1'b0, REG_STATUS, 32'h0, rdat);
		assert (rdat == exp)
			else fail_run($sformatf("error wb_dat_o got %h expected %h", rdat, exp));
	endtask

	initial begin
		clk_div   = 1'b0;
		reset     = 1'b1;
		lfsr      = 32'h7fe4_8fdd;
		rxd_r_i   = IDLE_NIB;
		rxd_f_i   = 4'h0;
		rxctl_r_i = 1'b0;
		rxctl_f_i = 1'b0;
		wb_cyc_i  = 1'b0;
		wb_stb_i  = 1'b0;
		wb_we_i   = 1'b0;
		wb_adr_i  = '0;
		wb_dat_i  = '0;
		repeat (8) @(posedge clk_div);
		#1;
		reset = 1'b0;
		// Idle line status with an empty queue
		check_status(5'd0, 1'b0);
		wb_access(1'b1, REG_CTRL, 32'h1 << CTRL_GIG, rdat);
		// Speed select reads back where it was written
		wb_access(1'b0, REG_CTRL, 32'h0, rdat);
		assert (rdat == (32'h1 << CTRL_GIG))
			else fail_run($sformatf("error wb_dat_o got %h expected %h",
				rdat, 32'h1 << CTRL_GIG));
		send_gig(5, -1);
		repeat (5) read_expect();
		expect_empty();
		// Error on one byte only
		send_gig(4, 1);
		repeat (4) read_expect();
		wb_access(1'b1, REG_CTRL, 32'h0, rdat);
		send_mii(4, -1, 1'b0);
		send_mii(3, 1, 1'b1);
		send_mii(3, 0, 1'b0);
		while (ref_q.size() > 0)
			read_expect();
		expect_empty();
		// Overflow with no reads during the frame
		wb_access(1'b1, REG_CTRL, 32'h1 << CTRL_GIG, rdat);
		send_gig(DEPTH + 4, -1);
		check_status(5'd16, 1'b1);
		repeat (DEPTH) read_expect();
		// Tail bytes were dropped by the full queue
		ref_q.delete();
		expect_empty();
		wb_access(1'b1, REG_CTRL, (32'h1 << CTRL_GIG) | (32'h1 << CTRL_CLR_OVF), rdat);
		check_status(5'd0, 1'b0);
		$display("sim passed");
		$finish;
	end

endmodule

// ==== bench/rgmii_rx_chk.sv ====
`timescale 1ns/1ps

module rgmii_rx_chk #(
	parameter int FIFO_DEPTH = 16
) (
	input logic                        clk_div,
	input logic                        reset,
	input logic                        cyc_i,
	input logic                        stb_i,
	input logic                        ack_i,
	input logic [$clog2(FIFO_DEPTH):0] level_i,
	input logic                        wr_en_i
);

	localparam int LW = $clog2(FIFO_DEPTH) + 1;

	// Upper bound of the level field
	localparam logic [LW-1:0] MAX_LEVEL = LW'(FIFO_DEPTH);

	// Ack answers a request seen one edge earlier
	ack_after_req: assert property (@(posedge clk_div) disable iff (reset)
		ack_i |-> $past(cyc_i && stb_i))
		else $error("ack raised without cyc and stb on the previous edge");

	// Single-cycle ack
	ack_one_cycle: assert property (@(posedge clk_div) disable iff (reset)
		ack_i |=> !ack_i)
		else $error("ack held high for two cycles");

	// Pointer difference stays inside the queue
	level_bound: assert property (@(posedge clk_div) disable iff (reset)
		level_i <= MAX_LEVEL)
		else $error("FIFO level above depth");

	// Producer quiet while held in reset
	no_write_in_reset: assert property (@(posedge clk_div)
		reset |-> !wr_en_i)
		else $error("FIFO write strobe high during reset");

endmodule

// ==== src/rgmii_rx_top.sv ====
`timescale 1ns/1ps

module rgmii_rx_top import rgmii_pkg::*, wb_regs_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                clk_div,
	input  logic                reset,
	input  logic [3:0]          rxd_r_i,
	input  logic [3:0]          rxd_f_i,
	input  logic                rxctl_r_i,
	input  logic                rxctl_f_i,
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	input  logic                wb_we_i,
	input  logic [WB_ADR_W-1:0] wb_adr_i,
	input  logic [WB_DAT_W-1:0] wb_dat_i,
	output logic                wb_ack_o,
	output logic [WB_DAT_W-1:0] wb_dat_o
);

	// Producer to queue
	logic               wr_en;
	logic [ENTRY_W-1:0] wr_entry;

	// Queue to register block
	logic [ENTRY_W-1:0]          rd_entry;
	logic                        empty;
	logic [$clog2(FIFO_DEPTH):0] level;
	logic                        overflow;
	logic                        rd_en;
	logic                        clr_ovf;

	// Side band between line side and registers
	inband_t status;
	logic    gig;

	rgmii_rx u_rgmii_rx (
		.clk_div(clk_div), .reset(reset), .gig_i(gig),
		.rxd_r_i(rxd_r_i), .rxd_f_i(rxd_f_i), .rxctl_r_i(rxctl_r_i), .rxctl_f_i(rxctl_f_i),
		.wr_en_o(wr_en), .wr_entry_o(wr_entry), .status_o(status)
	);

	rx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
		.clk_div(clk_div), .reset(reset), .wr_en_i(wr_en), .wr_entry_i(wr_entry),
		.rd_en_i(rd_en), .clr_ovf_i(clr_ovf), .rd_entry_o(rd_entry), .empty_o(empty),
		.level_o(level), .overflow_o(overflow)
	);

	rx_wb_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_wb_regs (
		.clk_div(clk_div), .reset(reset), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
		.rd_entry_i(rd_entry), .empty_i(empty), .level_i(level), .overflow_i(overflow),
		.status_i(status), .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o), .rd_en_o(rd_en),
		.clr_ovf_o(clr_ovf), .gig_o(gig)
	);

endmodule

// ==== src/rx_wb_regs.sv ====
`timescale 1ns/1ps

module rx_wb_regs import rgmii_pkg::*, wb_regs_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                        clk_div,
	input  logic                        reset,
	input  logic                        wb_cyc_i,
	input  logic                        wb_stb_i,
	input  logic                        wb_we_i,
	input  logic [WB_ADR_W-1:0]         wb_adr_i,
	input  logic [WB_DAT_W-1:0]         wb_dat_i,
	input  logic [ENTRY_W-1:0]          rd_entry_i,
	input  logic                        empty_i,
	input  logic [$clog2(FIFO_DEPTH):0] level_i,
	input  logic                        overflow_i,
	input  inband_t                     status_i,
	output logic                        wb_ack_o,
	output logic [WB_DAT_W-1:0]         wb_dat_o,
	output logic                        rd_en_o,
	output logic                        clr_ovf_o,
	output logic                        gig_o
);

	localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

	reg_addr_t           adr;
	logic                req;
	logic                ctrl_wr;
	logic [WB_DAT_W-1:0] rd_data;

	assign adr = reg_addr_t'(wb_adr_i);

	// New access only, the ack cycle itself is not a request
	assign req     = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign ctrl_wr = req && wb_we_i && (adr == REG_CTRL);

	always_comb begin
		rd_data = '0;
		case (adr)
			REG_DATA: begin
				// Entry bits line up with the register: last 9, err 8, byte 7:0
				rd_data[ENTRY_W-1:0] = rd_entry_i;
				rd_data[DATA_VALID]  = !empty_i;
			end
			REG_STATUS: begin
				rd_data[STAT_LINK]                = status_i.link_up;
				rd_data[STAT_SPEED +: 2]          = status_i.speed;
				rd_data[STAT_DUPLEX]              = status_i.duplex;
				rd_data[STAT_OVF]                 = overflow_i;
				rd_data[STAT_LEVEL +: LVL_W]      = level_i;
			end
			REG_CTRL: begin
				rd_data[CTRL_GIG] = gig_o;
			end
			default: begin
				rd_data = '0;
			end
		endcase
	end

	always_ff @(posedge clk_div or posedge reset) begin
		if (reset) begin
			wb_ack_o  <= 1'b0;
			rd_en_o   <= 1'b0;
			clr_ovf_o <= 1'b0;
			gig_o     <= 1'b0;
		end else begin
			wb_ack_o <= req;
			// Pop goes out together with the ack
			rd_en_o   <= req && !wb_we_i && (adr == REG_DATA) && !empty_i;
			clr_ovf_o <= ctrl_wr && wb_dat_i[CTRL_CLR_OVF];
			if (ctrl_wr)
				gig_o <= wb_dat_i[CTRL_GIG];
		end
	end

	// Read data captured on the request edge, seen with ack
	always_ff @(posedge clk_div) begin
		if (req && !wb_we_i)
			wb_dat_o <= rd_data;
	end

endmodule

// ==== src/rx_fifo.sv ====
`timescale 1ns/1ps

module rx_fifo import rgmii_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                        clk_div,
	input  logic                        reset,
	input  logic                        wr_en_i,
	input  logic [ENTRY_W-1:0]          wr_entry_i,
	input  logic                        rd_en_i,
	input  logic                        clr_ovf_i,
	output logic [ENTRY_W-1:0]          rd_entry_o,
	output logic                        empty_o,
	output logic [$clog2(FIFO_DEPTH):0] level_o,
	output logic                        overflow_o
);

	localparam int AW = $clog2(FIFO_DEPTH);

	logic [ENTRY_W-1:0] mem [FIFO_DEPTH];

	// Extra top bit tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        full;
	logic        do_wr;
	logic        do_rd;

	assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign empty_o = (wr_ptr == rd_ptr);
	assign level_o = wr_ptr - rd_ptr;

	// Writes into a full queue are lost
	assign do_wr = wr_en_i && !full;
	assign do_rd = rd_en_i && !empty_o;

	// Head of queue shown without a read stage
	assign rd_entry_o = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clk_div or posedge reset) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			// Sticky until the host clears it, a fresh drop wins
			if (wr_en_i && full)
				overflow_o <= 1'b1;
			else if (clr_ovf_i)
				overflow_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_div) begin
		if (do_wr)
			mem[wr_ptr[AW-1:0]] <= wr_entry_i;
	end

endmodule

// ==== rgmii_rx/rgmii_rx.sv ====
`timescale 1ns/1ps

module rgmii_rx import rgmii_pkg::*; (
	input  logic               clk_div,
	input  logic               reset,
	input  logic               gig_i,
	input  logic [3:0]         rxd_r_i,
	input  logic [3:0]         rxd_f_i,
	input  logic               rxctl_r_i,
	input  logic               rxctl_f_i,
	output logic               wr_en_o,
	output logic [ENTRY_W-1:0] wr_entry_o,
	output inband_t            status_o
);

	// Data valid on the rising edge, error coded as the edge difference
	logic dv;
	logic er;

	// 10/100 nibble pairing
	logic       phase;
	logic [3:0] low_nib;
	logic       low_err;

	// One-entry hold stage, lets the frame end tag the last byte
	logic       hold_valid;
	logic [7:0] hold_byte;
	logic       hold_err;

	// Byte completed this cycle
	logic       form;
	logic [7:0] form_byte;
	logic       form_err;

	// Frame ended with a byte still held
	logic flush;
	logic push;

	assign dv = rxctl_r_i;
	assign er = rxctl_r_i ^ rxctl_f_i;

	always_comb begin
		form      = 1'b0;
		form_byte = {rxd_f_i, rxd_r_i};
		form_err  = er;
		if (gig_i) begin
			// Falling nibble is the high half
			form = dv;
		end else if (phase) begin
			// Second nibble closes the byte whatever dv says
			form      = 1'b1;
			form_byte = {rxd_r_i, low_nib};
			form_err  = er | low_err;
		end
	end

	// dv low where a new byte would start ends the frame
	assign flush = hold_valid && !dv && (gig_i || !phase);
	assign push  = (form && hold_valid) || flush;

	always_ff @(posedge clk_div or posedge reset) begin
		if (reset) begin
			phase      <= 1'b0;
			hold_valid <= 1'b0;
			wr_en_o    <= 1'b0;
			status_o   <= '0;
		end else begin
			wr_en_o <= push;
			// Gigabit never waits for a second nibble
			if (gig_i)
				phase <= 1'b0;
			else if (phase)
				phase <= 1'b0;
			else
				phase <= dv;
			if (form)
				hold_valid <= 1'b1;
			else if (flush)
				hold_valid <= 1'b0;
			// Inter-frame cycles carry link status on rxd
			if (!dv && !er)
				status_o <= inband_t'(rxd_r_i);
		end
	end

	always_ff @(posedge clk_div) begin
		// Low nibble and its error wait here for the pair
		if (!phase) begin
			low_nib <= rxd_r_i;
			low_err <= er;
		end
		if (form) begin
			hold_byte <= form_byte;
			hold_err  <= form_err;
		end
		if (push) begin
			wr_entry_o[7:0]        <= hold_byte;
			wr_entry_o[ENTRY_ERR]  <= hold_err;
			wr_entry_o[ENTRY_LAST] <= flush;
		end
	end

endmodule

// ==== common/wb_regs_pkg.sv ====
package wb_regs_pkg;

	// Host bus widths
	localparam int WB_ADR_W = 4;
	localparam int WB_DAT_W = 32;

	// Register map, byte addresses
	typedef enum logic [WB_ADR_W-1:0] {
		REG_DATA   = 4'h0,
		REG_STATUS = 4'h4,
		REG_CTRL   = 4'h8
	} reg_addr_t;

	// Control register bits
	localparam int CTRL_GIG     = 0;
	localparam int CTRL_CLR_OVF = 1;

	// Status register fields
	localparam int STAT_LINK   = 0;
	localparam int STAT_SPEED  = 1;
	localparam int STAT_DUPLEX = 3;
	localparam int STAT_OVF    = 4;
	localparam int STAT_LEVEL  = 8;

	// Data register valid flag
	localparam int DATA_VALID = 31;

endpackage

// ==== common/rgmii_pkg.sv ====
package rgmii_pkg;

	// In-band speed code as sent by the PHY between frames
	typedef enum logic [1:0] {
		SPEED_10   = 2'b00,
		SPEED_100  = 2'b01,
		SPEED_1000 = 2'b10,
		SPEED_RSVD = 2'b11
	} link_speed_t;

	// One queued entry: data byte, error flag, last-byte flag
	localparam int ENTRY_W = 10;

	// Flag positions above the byte
	localparam int ENTRY_ERR  = 8;
	localparam int ENTRY_LAST = 9;

	// In-band status nibble, laid out as it arrives on rxd
	// bit 3 duplex, bits 2:1 speed, bit 0 link
	typedef struct packed {
		logic        duplex;
		link_speed_t speed;
		logic        link_up;
	} inband_t;

endpackage
